// ==== Bender.yml ====
package:
  name: hopAudio

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/audioPkg.sv
      - hdl/toneIf.sv
      - hdl/eventDetect.sv
      - hdl/cueArbiter.sv
      - hdl/noteSequencer.sv
      - hdl/toneGen.sv
      - hdl/audioTop.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - sim/audioTb.sv

// ==== all.f ====
+incdir+hdl
hdl/audioPkg.sv
hdl/toneIf.sv
hdl/eventDetect.sv
hdl/cueArbiter.sv
hdl/noteSequencer.sv
hdl/toneGen.sv
hdl/audioTop.sv
sim/audioTb.sv

// ==== hdl/audioPkg.sv ====
`default_nettype none

package audioPkg;

    // Phase of the game as reported by the game logic.
    typedef enum logic [1:0] {
        STATE_MENU    = 2'd0,
        STATE_PLAYING = 2'd1,
        STATE_DEAD    = 2'd2,
        STATE_WIN     = 2'd3
    } gameState_t;

    // Sound effect currently requested or sounding.
    typedef enum logic [1:0] {
        FX_NONE = 2'd0,
        FX_JUMP = 2'd1,
        FX_WIN  = 2'd2,
        FX_LOSE = 2'd3
    } effect_t;

    // Position within a melody. Four notes at most.
    typedef logic [1:0] noteIdx_t;

endpackage

`default_nettype wire

// ==== hdl/audioTop.sv ====
`default_nettype none

module audioTop (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 jumpForward,
    input  logic                 jumpBackward,
    input  logic                 jumpRight,
    input  logic                 jumpLeft,
    input  logic                 winIn,
    input  logic                 loseIn,
    input  audioPkg::gameState_t gameState,
    output logic                 sound,
    output logic                 playing,
    output audioPkg::effect_t    activeEffect
);

    logic              jumpReq;
    logic              winReq;
    logic              loseReq;
    logic              start;
    logic              done;
    audioPkg::effect_t startEffect;

    toneIf toneBus ();

    eventDetect u_eventDetect (
        .clk          (clk),
        .arstN        (arstN),
        .jumpForward  (jumpForward),
        .jumpBackward (jumpBackward),
        .jumpRight    (jumpRight),
        .jumpLeft     (jumpLeft),
        .winIn        (winIn),
        .loseIn       (loseIn),
        .gameState    (gameState),
        .jumpReq      (jumpReq),
        .winReq       (winReq),
        .loseReq      (loseReq)
    );

    cueArbiter u_cueArbiter (
        .clk          (clk),
        .arstN        (arstN),
        .jumpReq      (jumpReq),
        .winReq       (winReq),
        .loseReq      (loseReq),
        .done         (done),
        .start        (start),
        .startEffect  (startEffect),
        .activeEffect (activeEffect),
        .playing      (playing)
    );

    noteSequencer u_noteSequencer (
        .clk         (clk),
        .arstN       (arstN),
        .start       (start),
        .startEffect (startEffect),
        .done        (done),
        .tone        (toneBus.seq)
    );

    toneGen u_toneGen (
        .clk   (clk),
        .arstN (arstN),
        .tone  (toneBus.gen),
        .sound (sound)
    );

endmodule

`default_nettype wire

// ==== hdl/audio_defs.svh ====
`ifndef AUDIO_DEFS_SVH
`define AUDIO_DEFS_SVH

// Clock cycles spent on each melody note.
`define SND_NOTE_CYCLES 64

// Bits in a half-period count.
`define SND_HP_WIDTH 8

// Jump melody of two rising notes.
`define SND_JUMP_HP0 6
`define SND_JUMP_HP1 4

// Win melody of four climbing notes.
`define SND_WIN_HP0 8
`define SND_WIN_HP1 6
`define SND_WIN_HP2 5
`define SND_WIN_HP3 4

// Lose melody of three falling notes.
`define SND_LOSE_HP0 5
`define SND_LOSE_HP1 7
`define SND_LOSE_HP2 10

// Half periods are in clock cycles and must be at least 2.

`endif

// ==== hdl/cueArbiter.sv ====
`default_nettype none

module cueArbiter (
    input  logic              clk,
    input  logic              arstN,
    input  logic              jumpReq,
    input  logic              winReq,
    input  logic              loseReq,
    input  logic              done,
    output logic              start,
    output audioPkg::effect_t startEffect,
    output audioPkg::effect_t activeEffect,
    output logic              playing
);

    logic              anyReq;
    audioPkg::effect_t chosen;

    assign anyReq = jumpReq | winReq | loseReq;

    // Jump beats win, win beats lose.
    always_comb begin
        if (jumpReq) begin
            chosen = audioPkg::FX_JUMP;
        end else if (winReq) begin
            chosen = audioPkg::FX_WIN;
        end else if (loseReq) begin
            chosen = audioPkg::FX_LOSE;
        end else begin
            chosen = audioPkg::FX_NONE;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            start       <= 1'b0;
            startEffect <= audioPkg::FX_NONE;
        end else begin
            start <= anyReq;
            if (anyReq) begin
                startEffect <= chosen;
            end
        end
    end

    // A start always wins over a done in the same cycle.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            activeEffect <= audioPkg::FX_NONE;
            playing      <= 1'b0;
        end else if (start) begin
            activeEffect <= startEffect;
            playing      <= 1'b1;
        end else if (done) begin
            activeEffect <= audioPkg::FX_NONE;
            playing      <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/eventDetect.sv ====
`default_nettype none

module eventDetect (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 jumpForward,
    input  logic                 jumpBackward,
    input  logic                 jumpRight,
    input  logic                 jumpLeft,
    input  logic                 winIn,
    input  logic                 loseIn,
    input  audioPkg::gameState_t gameState,
    output logic                 jumpReq,
    output logic                 winReq,
    output logic                 loseReq
);

    logic anyJump;
    logic jumpReg;
    logic winReg;
    logic loseReg;
    logic jumpPrev;
    logic winPrev;
    logic losePrev;
    audioPkg::gameState_t stateReg;

    assign anyJump = jumpForward | jumpBackward | jumpRight | jumpLeft;

    // Inputs sampled once, then delayed a cycle for edge detection.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            jumpReg  <= 1'b0;
            winReg   <= 1'b0;
            loseReg  <= 1'b0;
            jumpPrev <= 1'b0;
            winPrev  <= 1'b0;
            losePrev <= 1'b0;
            stateReg <= audioPkg::STATE_MENU;
        end else begin
            jumpReg  <= anyJump;
            winReg   <= winIn;
            loseReg  <= loseIn;
            jumpPrev <= jumpReg;
            winPrev  <= winReg;
            losePrev <= loseReg;
            stateReg <= gameState;
        end
    end

    // Jumps only make noise during play.
    assign jumpReq = jumpReg & ~jumpPrev & (stateReg == audioPkg::STATE_PLAYING);
    assign winReq  = winReg & ~winPrev;
    assign loseReq = loseReg & ~losePrev;

endmodule

`default_nettype wire

// ==== hdl/noteSequencer.sv ====
`include "audio_defs.svh"

`default_nettype none

module noteSequencer (
    input  logic              clk,
    input  logic              arstN,
    input  logic              start,
    input  audioPkg::effect_t startEffect,
    output logic              done,
    toneIf.seq                tone
);

    localparam int CntWidth = $clog2(`SND_NOTE_CYCLES);
    localparam logic [CntWidth-1:0] NoteLast = CntWidth'(`SND_NOTE_CYCLES - 1);

    audioPkg::effect_t   effect;
    audioPkg::noteIdx_t  noteIdx;
    audioPkg::noteIdx_t  nextIdx;
    logic [CntWidth-1:0] noteCnt;
    logic                noteEnd;
    logic                lastNote;

    // Note table of every effect.
    function automatic logic [`SND_HP_WIDTH-1:0] notePeriod(
        input audioPkg::effect_t  fx,
        input audioPkg::noteIdx_t idx
    );
        logic [`SND_HP_WIDTH-1:0] hp;
        hp = '0;
        case (fx)
            audioPkg::FX_JUMP: begin
                case (idx)
                    2'd0:    hp = `SND_HP_WIDTH'(`SND_JUMP_HP0);
                    default: hp = `SND_HP_WIDTH'(`SND_JUMP_HP1);
                endcase
            end
            audioPkg::FX_WIN: begin
                case (idx)
                    2'd0:    hp = `SND_HP_WIDTH'(`SND_WIN_HP0);
                    2'd1:    hp = `SND_HP_WIDTH'(`SND_WIN_HP1);
                    2'd2:    hp = `SND_HP_WIDTH'(`SND_WIN_HP2);
                    default: hp = `SND_HP_WIDTH'(`SND_WIN_HP3);
                endcase
            end
            audioPkg::FX_LOSE: begin
                case (idx)
                    2'd0:    hp = `SND_HP_WIDTH'(`SND_LOSE_HP0);
                    2'd1:    hp = `SND_HP_WIDTH'(`SND_LOSE_HP1);
                    default: hp = `SND_HP_WIDTH'(`SND_LOSE_HP2);
                endcase
            end
            default: hp = '0;
        endcase
        return hp;
    endfunction

    // Index of the final note of each melody.
    function automatic audioPkg::noteIdx_t lastIdx(input audioPkg::effect_t fx);
        case (fx)
            audioPkg::FX_JUMP: return 2'd1;
            audioPkg::FX_WIN:  return 2'd3;
            audioPkg::FX_LOSE: return 2'd2;
            default:           return 2'd0;
        endcase
    endfunction

    assign nextIdx  = noteIdx + 1'b1;
    assign noteEnd  = tone.active && (noteCnt == '0);
    assign lastNote = (noteIdx == lastIdx(effect));
    assign done     = noteEnd && lastNote; // Last cycle of last note.

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            effect       <= audioPkg::FX_NONE;
            noteIdx      <= '0;
            noteCnt      <= '0;
            tone.load    <= 1'b0;
            tone.restart <= 1'b0;
            tone.active  <= 1'b0;
        end else begin
            tone.load    <= 1'b0;
            tone.restart <= 1'b0;
            if (start) begin
                effect       <= startEffect;
                noteIdx      <= '0;
                noteCnt      <= NoteLast;
                tone.load    <= 1'b1;
                tone.restart <= 1'b1;
                tone.active  <= (startEffect != audioPkg::FX_NONE);
            end else if (noteEnd) begin
                if (lastNote) begin
                    tone.active <= 1'b0;
                end else begin
                    noteIdx   <= nextIdx;
                    noteCnt   <= NoteLast;
                    tone.load <= 1'b1;
                end
            end else if (tone.active) begin
                noteCnt <= noteCnt - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            tone.halfPeriod <= notePeriod(startEffect, '0);
        end else if (noteEnd && !lastNote) begin
            tone.halfPeriod <= notePeriod(effect, nextIdx);
        end
    end

endmodule

`default_nettype wire

// ==== hdl/toneGen.sv ====
`include "audio_defs.svh"

`default_nettype none

module toneGen (
    input  logic clk,
    input  logic arstN,
    toneIf.gen   tone,
    output logic sound
);

    logic [`SND_HP_WIDTH-1:0] halfCnt;
    logic                     phase;

    // The load edge itself counts as the first cycle of a half period,
    // so the count starts two short of the half period.
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            halfCnt <= '0;
            phase   <= 1'b0;
        end else if (tone.load) begin
            halfCnt <= tone.halfPeriod - `SND_HP_WIDTH'(2);
            if (tone.restart) begin
                phase <= 1'b0;
            end
        end else if (tone.active) begin
            if (halfCnt == '0) begin
                phase   <= ~phase;
                halfCnt <= tone.halfPeriod - `SND_HP_WIDTH'(1);
            end else begin
                halfCnt <= halfCnt - 1'b1;
            end
        end else begin
            phase <= 1'b0; // Idle wave rests low.
        end
    end

    // Old phase is masked while a restart is still in flight.
    assign sound = tone.active & ~tone.restart & phase;

endmodule

`default_nettype wire

// ==== hdl/toneIf.sv ====
`include "audio_defs.svh"

`default_nettype none

interface toneIf;

    logic                     load;       // New half period valid.
    logic [`SND_HP_WIDTH-1:0] halfPeriod;
    logic                     active;     // Level, high while a melody sounds.
    logic                     restart;    // First note of a melody.

    modport seq (
        output load,
        output halfPeriod,
        output active,
        output restart
    );

    modport gen (
        input  load,
        input  halfPeriod,
        input  active,
        input  restart
    );

endinterface

`default_nettype wire

// ==== sim/audioTb.sv ====
`include "audio_defs.svh"

`default_nettype none

module audioTb;

    localparam int ClkPeriod      = 8;
    localparam int NoteCycles     = `SND_NOTE_CYCLES;
    localparam int MelodyMax      = 4 * NoteCycles + 16; // Longest melody plus pipeline slack.
    localparam int WatchdogCycles = 14 * MelodyMax + 1000;

    logic                 clk;
    logic                 arstN;
    logic                 jumpForward;
    logic                 jumpBackward;
    logic                 jumpRight;
    logic                 jumpLeft;
    logic                 winIn;
    logic                 loseIn;
    audioPkg::gameState_t gameState;
    logic                 sound;
    logic                 playing;
    audioPkg::effect_t    activeEffect;

    int unsigned lcgState;
    int          errCount;
    int          testErrStart;
    int          testsRun;
    int          testsFailed;

    // Reference model.
    logic              mJumpPrev;
    logic              mWinPrev;
    logic              mLosePrev;
    audioPkg::effect_t mPend1;
    audioPkg::effect_t mPend2;
    audioPkg::effect_t mEffect;
    logic              mPlaying;
    logic              mPhase;
    int                mNote;
    int                mCnt;
    int                mHp;
    logic              mSound;

    audioTop u_audioTop (
        .clk          (clk),
        .arstN        (arstN),
        .jumpForward  (jumpForward),
        .jumpBackward (jumpBackward),
        .jumpRight    (jumpRight),
        .jumpLeft     (jumpLeft),
        .winIn        (winIn),
        .loseIn       (loseIn),
        .gameState    (gameState),
        .sound        (sound),
        .playing      (playing),
        .activeEffect (activeEffect)
    );

    always #(ClkPeriod / 2) clk = ~clk;

    function automatic int unsigned randBelow(input int unsigned n);
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return (lcgState >> 8) % n;
    endfunction

    function automatic int melodyHalfPeriod(input audioPkg::effect_t fx, input int idx);
        int hp;
        hp = 0;
        if (fx == audioPkg::FX_JUMP) begin
            hp = (idx == 0) ? `SND_JUMP_HP0 : `SND_JUMP_HP1;
        end else if (fx == audioPkg::FX_WIN) begin
            case (idx)
                0:       hp = `SND_WIN_HP0;
                1:       hp = `SND_WIN_HP1;
                2:       hp = `SND_WIN_HP2;
                default: hp = `SND_WIN_HP3;
            endcase
        end else if (fx == audioPkg::FX_LOSE) begin
            case (idx)
                0:       hp = `SND_LOSE_HP0;
                1:       hp = `SND_LOSE_HP1;
                default: hp = `SND_LOSE_HP2;
            endcase
        end
        return hp;
    endfunction

    function automatic int melodyLength(input audioPkg::effect_t fx);
        case (fx)
            audioPkg::FX_JUMP: return 2;
            audioPkg::FX_WIN:  return 4;
            audioPkg::FX_LOSE: return 3;
            default:           return 0;
        endcase
    endfunction

    // Request picked at edge t starts its melody at edge t+2.
    always @(posedge clk or negedge arstN) begin
        logic              jumpNow;
        audioPkg::effect_t pick;
        if (!arstN) begin
            mJumpPrev = 1'b0;
            mWinPrev  = 1'b0;
            mLosePrev = 1'b0;
            mPend1    = audioPkg::FX_NONE;
            mPend2    = audioPkg::FX_NONE;
            mEffect   = audioPkg::FX_NONE;
            mPlaying  = 1'b0;
            mPhase    = 1'b0;
            mNote     = 0;
            mCnt      = 0;
            mHp       = 2;
        end else begin
            jumpNow = jumpForward | jumpBackward | jumpRight | jumpLeft;
            if (jumpNow && !mJumpPrev && gameState == audioPkg::STATE_PLAYING) begin
                pick = audioPkg::FX_JUMP;
            end else if (winIn && !mWinPrev) begin
                pick = audioPkg::FX_WIN;
            end else if (loseIn && !mLosePrev) begin
                pick = audioPkg::FX_LOSE;
            end else begin
                pick = audioPkg::FX_NONE;
            end
            mJumpPrev = jumpNow;
            mWinPrev  = winIn;
            mLosePrev = loseIn;
            if (mPend2 != audioPkg::FX_NONE) begin
                mEffect  = mPend2;
                mPlaying = 1'b1;
                mNote    = 0;
                mCnt     = 0;
                mPhase   = 1'b0; // Every melody opens low.
                mHp      = melodyHalfPeriod(mPend2, 0);
            end else if (mPlaying) begin
                mCnt = mCnt + 1;
                if (mCnt % mHp == 0) begin
                    mPhase = !mPhase;
                end
                if (mCnt == NoteCycles) begin
                    if (mNote == melodyLength(mEffect) - 1) begin
                        mPlaying = 1'b0;
                        mEffect  = audioPkg::FX_NONE;
                        mPhase   = 1'b0;
                    end else begin
                        mNote = mNote + 1;
                        mCnt  = 0;
                        mHp   = melodyHalfPeriod(mEffect, mNote);
                    end
                end
            end
            mPend2 = mPend1;
            mPend1 = pick;
        end
    end

    assign mSound = mPlaying & mPhase;

    // Model and DUT compared mid-cycle.
    always @(negedge clk) begin
        if (arstN) begin
            assert (sound === mSound) else begin
                $display("mismatch at time %0t: sound expected %b actual %b",
                         $time, mSound, sound);
                errCount++;
            end
            assert (playing === mPlaying) else begin
                $display("mismatch at time %0t: playing expected %b actual %b",
                         $time, mPlaying, playing);
                errCount++;
            end
            assert (activeEffect === mEffect) else begin
                $display("mismatch at time %0t: activeEffect expected %0d actual %0d",
                         $time, mEffect, activeEffect);
                errCount++;
            end
        end
    end

    initial begin
        #(WatchdogCycles * ClkPeriod);
        $display("watchdog expired after %0d cycles, the run did not complete", WatchdogCycles);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic idleCycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic setState(input audioPkg::gameState_t s);
        @(posedge clk);
        gameState <= s;
    endtask

    task automatic raiseCues(input logic jump, input logic win, input logic lose);
        int button;
        button = randBelow(4);
        @(posedge clk);
        if (jump) begin
            case (button)
                0:       jumpForward  <= 1'b1;
                1:       jumpBackward <= 1'b1;
                2:       jumpRight    <= 1'b1;
                default: jumpLeft     <= 1'b1;
            endcase
        end
        winIn  <= win;
        loseIn <= lose;
    endtask

    task automatic dropCues();
        @(posedge clk);
        jumpForward  <= 1'b0;
        jumpBackward <= 1'b0;
        jumpRight    <= 1'b0;
        jumpLeft     <= 1'b0;
        winIn        <= 1'b0;
        loseIn       <= 1'b0;
    endtask

    task automatic waitPlaying(input logic level, input int limit, input string what);
        int count;
        count = 0;
        @(negedge clk);
        while (playing !== level && count < limit) begin
            @(negedge clk);
            count++;
        end
        if (playing !== level) begin
            $display("timeout at %0t waiting for playing to go %b during %s", $time, level, what);
            errCount++;
        end
    endtask

    task automatic playCue(input logic jump, input logic win, input logic lose,
                           input string what);
        raiseCues(jump, win, lose);
        idleCycles(1 + randBelow(4));
        dropCues();
        waitPlaying(1'b1, 8, what);
        waitPlaying(1'b0, MelodyMax, what);
    endtask

    task automatic endTest(input int num, input string name);
        testsRun++;
        if (errCount == testErrStart) begin
            $display("test %0d %s: passed", num, name);
        end else begin
            testsFailed++;
            $display("test %0d %s: failed with %0d errors", num, name, errCount - testErrStart);
        end
        testErrStart = errCount;
    endtask

    initial begin
        lcgState     = 91065;
        errCount     = 0;
        testErrStart = 0;
        testsRun     = 0;
        testsFailed  = 0;
        clk          = 1'b0;
        arstN        = 1'b0;
        jumpForward  = 1'b0;
        jumpBackward = 1'b0;
        jumpRight    = 1'b0;
        jumpLeft     = 1'b0;
        winIn        = 1'b0;
        loseIn       = 1'b0;
        gameState    = audioPkg::STATE_MENU;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;

        idleCycles(20);
        raiseCues(1'b0, 1'b1, 1'b0); // Held for far longer than one melody.
        waitPlaying(1'b1, 8, "held win");
        waitPlaying(1'b0, MelodyMax, "held win");
        idleCycles(40);
        dropCues();
        idleCycles(5);
        endTest(1, "reset and idle");

        setState(audioPkg::STATE_PLAYING);
        playCue(1'b1, 1'b0, 1'b0, "jump melody");
        setState(audioPkg::STATE_MENU);
        raiseCues(1'b1, 1'b0, 1'b0);
        idleCycles(10);
        dropCues();
        setState(audioPkg::STATE_DEAD);
        raiseCues(1'b1, 1'b0, 1'b0);
        idleCycles(10);
        dropCues();
        setState(audioPkg::STATE_WIN);
        raiseCues(1'b1, 1'b0, 1'b0);
        idleCycles(10);
        dropCues();
        idleCycles(5);
        endTest(2, "jump gating and melody");

        setState(audioPkg::gameState_t'(randBelow(4)));
        playCue(1'b0, 1'b1, 1'b0, "win melody");
        setState(audioPkg::gameState_t'(randBelow(4)));
        playCue(1'b0, 1'b0, 1'b1, "lose melody");
        endTest(3, "win and lose melodies");

        setState(audioPkg::STATE_PLAYING);
        playCue(1'b1, 1'b1, 1'b1, "jump over win and lose");
        playCue(1'b0, 1'b1, 1'b1, "win over lose");
        setState(audioPkg::STATE_DEAD);
        playCue(1'b1, 1'b0, 1'b1, "gated jump with lose");
        endTest(4, "priority");

        setState(audioPkg::STATE_PLAYING);
        raiseCues(1'b0, 1'b0, 1'b1);
        idleCycles(2);
        dropCues();
        idleCycles(10 + randBelow(150)); // Lands inside the lose melody.
        raiseCues(1'b1, 1'b0, 1'b0);
        idleCycles(2);
        dropCues();
        idleCycles(10 + randBelow(100));
        raiseCues(1'b0, 1'b1, 1'b0);
        idleCycles(1);
        dropCues();
        waitPlaying(1'b0, MelodyMax, "override");
        idleCycles(10);
        endTest(5, "override");

        $display("tests run %0d, tests failed %0d, errors %0d", testsRun, testsFailed, errCount);
        if (errCount == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
